// ==== hdl/disc_defs.svh ====
/* channel counts, sample and timestamp widths, delay line depth and
   configuration field widths for the sample discriminator */

`ifndef DISC_DEFS_SVH
`define DISC_DEFS_SVH

// adc receive channels and digital trigger inputs
`define DISC_CHANNELS 4
`define DISC_DIG_CHANNELS 2

// signed adc sample
`define DISC_SAMPLE_WIDTH 16

// delay line length, start/stop/hold delays stay below it
`define DISC_DELAY_DEPTH 32
`define DISC_TIMER_BITS 5

`define DISC_TSTAMP_WIDTH 32

// 0..3 analog channel, 4..5 digital input
`define DISC_SRC_BITS 3

`endif

// ==== hdl/disc_pkg.sv ====
/* sample, channel bus, per-channel configuration and timestamp bus types */

package disc_pkg;

  `include "disc_defs.svh"

  typedef logic signed [`DISC_SAMPLE_WIDTH-1:0] sample_t;

  // one valid bit and one sample per channel
  typedef struct packed {
    logic [`DISC_CHANNELS-1:0] valid;
    sample_t [`DISC_CHANNELS-1:0] data;
  } chan_bus_t;

  // static per-channel settings, changed only under reset-state
  typedef struct packed {
    sample_t low_thresh;
    sample_t high_thresh;
    logic [`DISC_TIMER_BITS-1:0] start_delay;
    logic [`DISC_TIMER_BITS-1:0] stop_delay;
    // only used from channels 0 and 1, one per digital input
    logic [`DISC_TIMER_BITS-1:0] dig_hold;
    logic [`DISC_SRC_BITS-1:0] source;
    logic bypass;
  } chan_cfg_t;

  typedef chan_cfg_t [`DISC_CHANNELS-1:0] disc_cfg_t;

  // burst start timestamps, one per channel
  typedef struct packed {
    logic [`DISC_CHANNELS-1:0] valid;
    logic [`DISC_CHANNELS-1:0][`DISC_TSTAMP_WIDTH-1:0] tstamp;
  } tstamp_bus_t;

endpackage

// ==== hdl/hysteresis_trigger.sv ====
/* analog trigger with per-channel hysteresis between low and high thresholds */

`timescale 1ns/1ps
`include "disc_defs.svh"

module hysteresis_trigger (
  input  logic                      adc_clk,
  input  logic                      reset_i,
  input  logic                      adc_reset_state_i,
  input  disc_pkg::chan_bus_t       adc_data_i,
  input  disc_pkg::disc_cfg_t       cfg_i,
  output logic [`DISC_CHANNELS-1:0] analog_trig_o
);

  import disc_pkg::*;

  logic [`DISC_CHANNELS-1:0] above_high;
  logic [`DISC_CHANNELS-1:0] below_low;
  logic [`DISC_CHANNELS-1:0] trig_state;

  // signed threshold compares
  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      above_high[ch] = sample_t'(adc_data_i.data[ch]) > sample_t'(cfg_i[ch].high_thresh);
      below_low[ch] = sample_t'(adc_data_i.data[ch]) < sample_t'(cfg_i[ch].low_thresh);
    end
  end

  // set above high, clear below low, hold in between
  always_ff @(posedge adc_clk) begin
    if (reset_i || adc_reset_state_i) begin
      trig_state <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        if (adc_data_i.valid[ch]) begin
          if (above_high[ch]) begin
            trig_state[ch] <= 1'b1;
          end else if (below_low[ch]) begin
            trig_state[ch] <= 1'b0;
          end
        end
      end
    end
  end

  assign analog_trig_o = trig_state;

  // a crossed pair of thresholds would make the flag depend on compare order
  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_thresh_chk
    assert property (@(posedge adc_clk) disable iff (reset_i)
      $signed(cfg_i[ch].low_thresh) <= $signed(cfg_i[ch].high_thresh))
      else $error("channel %0d low_thresh above high_thresh", ch);
  end

endmodule

// ==== hdl/sample_discriminator.sv ====
/* top level of the discriminator: trigger stages, data alignment registers
   and one sample gate per channel */

`timescale 1ns/1ps
`include "disc_defs.svh"

module sample_discriminator (
  input  logic                          adc_clk,
  input  logic                          reset_i,
  input  logic                          adc_reset_state_i,
  input  disc_pkg::chan_bus_t           adc_data_i,
  input  logic [`DISC_DIG_CHANNELS-1:0] adc_digital_trigger_i,
  input  disc_pkg::disc_cfg_t           cfg_i,
  output disc_pkg::chan_bus_t           adc_data_o,
  output disc_pkg::tstamp_bus_t         adc_tstamp_o
);

  import disc_pkg::*;

  logic [`DISC_CHANNELS-1:0] analog_trig;
  logic [`DISC_CHANNELS-1:0] chan_trig;

  chan_bus_t data_q1;
  chan_bus_t data_d;

  logic gate_valid [`DISC_CHANNELS];
  sample_t gate_sample [`DISC_CHANNELS];
  logic gate_tvalid [`DISC_CHANNELS];
  logic [`DISC_TSTAMP_WIDTH-1:0] gate_tstamp [`DISC_CHANNELS];

  hysteresis_trigger hysteresis_trigger_inst (
    .adc_clk           (adc_clk),
    .reset_i           (reset_i),
    .adc_reset_state_i (adc_reset_state_i),
    .adc_data_i        (adc_data_i),
    .cfg_i             (cfg_i),
    .analog_trig_o     (analog_trig)
  );

  trigger_select trigger_select_inst (
    .adc_clk               (adc_clk),
    .reset_i               (reset_i),
    .adc_reset_state_i     (adc_reset_state_i),
    .adc_valid_i           (|adc_data_i.valid),
    .analog_trig_i         (analog_trig),
    .adc_digital_trigger_i (adc_digital_trigger_i),
    .cfg_i                 (cfg_i),
    .chan_trig_o           (chan_trig)
  );

  // two stages to line samples up with chan_trig
  // valids are flushed under reset-state so no old sample leaks out
  always_ff @(posedge adc_clk) begin
    data_q1.data <= adc_data_i.data;
    data_d.data <= data_q1.data;
    if (reset_i || adc_reset_state_i) begin
      data_q1.valid <= '0;
      data_d.valid <= '0;
    end else begin
      data_q1.valid <= adc_data_i.valid;
      data_d.valid <= data_q1.valid;
    end
  end

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_chan
    sample_gate sample_gate_inst (
      .adc_clk           (adc_clk),
      .reset_i           (reset_i),
      .adc_reset_state_i (adc_reset_state_i),
      .valid_i           (data_d.valid[ch]),
      .sample_i          (data_d.data[ch]),
      .trig_i            (chan_trig[ch]),
      .cfg_i             (cfg_i[ch]),
      .valid_o           (gate_valid[ch]),
      .sample_o          (gate_sample[ch]),
      .tstamp_valid_o    (gate_tvalid[ch]),
      .tstamp_o          (gate_tstamp[ch])
    );
  end

  // gather per-channel results onto the output buses
  always_comb begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      adc_data_o.valid[ch] = gate_valid[ch];
      adc_data_o.data[ch] = gate_sample[ch];
      adc_tstamp_o.valid[ch] = gate_tvalid[ch];
      adc_tstamp_o.tstamp[ch] = gate_tstamp[ch];
    end
  end

endmodule

// ==== hdl/sample_gate.sv ====
/* one channel's pre-trigger delay line, gate window countdown, bypass path
   and burst timestamp counter */

`timescale 1ns/1ps
`include "disc_defs.svh"

module sample_gate (
  input  logic                          adc_clk,
  input  logic                          reset_i,
  input  logic                          adc_reset_state_i,
  input  logic                          valid_i,
  input  disc_pkg::sample_t             sample_i,
  input  logic                          trig_i,
  input  disc_pkg::chan_cfg_t           cfg_i,
  output logic                          valid_o,
  output disc_pkg::sample_t             sample_o,
  output logic                          tstamp_valid_o,
  output logic [`DISC_TSTAMP_WIDTH-1:0] tstamp_o
);

  import disc_pkg::*;

  sample_t delay_mem [`DISC_DELAY_DEPTH];
  sample_t tap_sample;

  logic [`DISC_TIMER_BITS-1:0] wr_ptr;
  logic [`DISC_TIMER_BITS-1:0] rd_ptr;
  // samples stored since reset-state, saturating
  logic [`DISC_TIMER_BITS-1:0] fill_cnt;
  logic [`DISC_TIMER_BITS:0] window_len;
  logic [`DISC_TIMER_BITS:0] post_cnt;
  // index of the sample arriving now
  logic [`DISC_TSTAMP_WIDTH-1:0] sample_idx;
  logic [`DISC_TSTAMP_WIDTH-1:0] start_ext;

  logic fill_ok;
  logic gate_open;
  logic rel_sample;
  logic prev_rel;

  ////////////////////////////////////////////////////////////////////////////
  // delay line
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      delay_mem[wr_ptr] <= sample_i;
    end
  end

  // tap start_delay samples back, zero delay takes the live sample
  assign rd_ptr = wr_ptr - cfg_i.start_delay;
  assign tap_sample = (cfg_i.start_delay == '0) ? sample_i : delay_mem[rd_ptr];
  assign fill_ok = fill_cnt >= cfg_i.start_delay;

  ////////////////////////////////////////////////////////////////////////////
  // gate window
  ////////////////////////////////////////////////////////////////////////////
  // the released sample trails the trigger by start_delay, so the window
  // after trigger fall covers both delays
  assign window_len = {1'b0, cfg_i.start_delay} + {1'b0, cfg_i.stop_delay};
  assign gate_open = trig_i || (post_cnt != '0);
  assign rel_sample = valid_i && fill_ok && gate_open;

  assign start_ext = {{(`DISC_TSTAMP_WIDTH-`DISC_TIMER_BITS){1'b0}}, cfg_i.start_delay};

  always_ff @(posedge adc_clk) begin
    if (reset_i || adc_reset_state_i) begin
      wr_ptr <= '0;
      fill_cnt <= '0;
      post_cnt <= '0;
      sample_idx <= '0;
      prev_rel <= 1'b0;
    end else if (valid_i) begin
      wr_ptr <= wr_ptr + 1'b1;
      if (fill_cnt != '1) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      if (trig_i) begin
        post_cnt <= window_len;
      end else if (post_cnt != '0) begin
        post_cnt <= post_cnt - 1'b1;
      end
      sample_idx <= sample_idx + 1'b1;
      prev_rel <= rel_sample;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (reset_i || adc_reset_state_i) begin
      valid_o <= 1'b0;
      tstamp_valid_o <= 1'b0;
    end else begin
      valid_o <= cfg_i.bypass ? valid_i : rel_sample;
      // first released sample after a closed gate starts a burst
      tstamp_valid_o <= !cfg_i.bypass && rel_sample && !prev_rel;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      sample_o <= cfg_i.bypass ? sample_i : tap_sample;
      tstamp_o <= sample_idx - start_ext;
    end
  end

  // a longer window would let the countdown wrap past the line depth
  assert property (@(posedge adc_clk) disable iff (reset_i)
    window_len < `DISC_DELAY_DEPTH)
    else $error("start_delay + stop_delay = %0d exceeds delay depth", window_len);

  assert property (@(posedge adc_clk) disable iff (reset_i)
    tstamp_valid_o |-> valid_o)
    else $error("timestamp issued without an output sample");

endmodule

// ==== hdl/trigger_select.sv ====
/* digital trigger pulse stretchers and the registered per-channel trigger
   source multiplexer */

`timescale 1ns/1ps
`include "disc_defs.svh"

module trigger_select (
  input  logic                          adc_clk,
  input  logic                          reset_i,
  input  logic                          adc_reset_state_i,
  input  logic                          adc_valid_i,
  input  logic [`DISC_CHANNELS-1:0]     analog_trig_i,
  input  logic [`DISC_DIG_CHANNELS-1:0] adc_digital_trigger_i,
  input  disc_pkg::disc_cfg_t           cfg_i,
  output logic [`DISC_CHANNELS-1:0]     chan_trig_o
);

  // remaining samples the digital level may still cover
  logic [`DISC_DIG_CHANNELS-1:0][`DISC_TIMER_BITS:0] hold_cnt;
  logic [`DISC_DIG_CHANNELS-1:0] dig_level;
  // analog sources in the low bits, digital above them
  logic [`DISC_CHANNELS+`DISC_DIG_CHANNELS-1:0] trig_src;

  ////////////////////////////////////////////////////////////////////////////
  // pulse stretchers, counted in valid samples
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (reset_i || adc_reset_state_i) begin
      hold_cnt <= '0;
      dig_level <= '0;
    end else begin
      for (int d = 0; d < `DISC_DIG_CHANNELS; d++) begin
        if (adc_valid_i) begin
          // a pulse on a valid cycle covers that sample too
          if (adc_digital_trigger_i[d] || hold_cnt[d] != '0) begin
            dig_level[d] <= 1'b1;
            hold_cnt[d] <= adc_digital_trigger_i[d] ? {1'b0, cfg_i[d].dig_hold}
                                                    : hold_cnt[d] - 1'b1;
          end else begin
            dig_level[d] <= 1'b0;
          end
        end else if (adc_digital_trigger_i[d]) begin
          dig_level[d] <= 1'b1;
          hold_cnt[d] <= {1'b0, cfg_i[d].dig_hold} + 1'b1;
        end
      end
    end
  end

  assign trig_src = {dig_level, analog_trig_i};

  ////////////////////////////////////////////////////////////////////////////
  // source multiplexer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (reset_i || adc_reset_state_i) begin
      chan_trig_o <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        if (cfg_i[ch].source < `DISC_CHANNELS + `DISC_DIG_CHANNELS) begin
          chan_trig_o[ch] <= trig_src[cfg_i[ch].source];
        end else begin
          chan_trig_o[ch] <= 1'b0;
        end
      end
    end
  end

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_src_chk
    assert property (@(posedge adc_clk) disable iff (reset_i)
      cfg_i[ch].source < `DISC_CHANNELS + `DISC_DIG_CHANNELS)
      else $error("channel %0d selects illegal source %0d", ch, cfg_i[ch].source);
  end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/disc_pkg.sv
hdl/hysteresis_trigger.sv
hdl/trigger_select.sv
hdl/sample_gate.sv
hdl/sample_discriminator.sv
verification/sample_discriminator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the sample discriminator testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module sample_discriminator_tb -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "RESULT: FAIL" "$log"; then
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "RESULT: PASS" "$log"; then
  echo "simulation log holds no pass line"
  exit 1
fi
exit 0

// ==== verification/sample_discriminator_tb.sv ====
/* testbench for the sample discriminator: clock, reset, random runs,
   reference model queues and output checking assertions */

`timescale 1ns/1ps
`include "disc_defs.svh"

module sample_discriminator_tb;

  import disc_pkg::*;

  localparam int RUN_LEN = 200;
  localparam int NUM_RUNS = 8;
  localparam int DRAIN_LIMIT = 200;

  // one output lane as seen at the falling edge
  typedef struct packed {
    logic valid;
    logic have;
    logic [31:0] exp;
    logic [31:0] got;
  } out_check_t;

  logic adc_clk;
  logic reset_i;
  logic adc_reset_state_i;
  chan_bus_t adc_data_i;
  logic [`DISC_DIG_CHANNELS-1:0] adc_digital_trigger_i;
  disc_cfg_t cfg;
  chan_bus_t adc_data_o;
  tstamp_bus_t adc_tstamp_o;

  string test_name;
  sample_t smp [`DISC_CHANNELS][RUN_LEN];
  logic [1:0] pulse [RUN_LEN];
  int gap [RUN_LEN];
  bit lvl [`DISC_CHANNELS][RUN_LEN];
  logic [31:0] exp_smp_q [`DISC_CHANNELS][$];
  logic [31:0] exp_ts_q [`DISC_CHANNELS][$];
  out_check_t smp_chk [`DISC_CHANNELS];
  out_check_t ts_chk [`DISC_CHANNELS];

  sample_discriminator sample_discriminator_inst (
    .adc_clk               (adc_clk),
    .reset_i               (reset_i),
    .adc_reset_state_i     (adc_reset_state_i),
    .adc_data_i            (adc_data_i),
    .adc_digital_trigger_i (adc_digital_trigger_i),
    .cfg_i                 (cfg),
    .adc_data_o            (adc_data_o),
    .adc_tstamp_o          (adc_tstamp_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever begin
      #2 adc_clk = ~adc_clk;
    end
  end

  task automatic stop_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(string what, int ch, logic [31:0] exp, logic [31:0] got);
    $display("ERR test=%s ch=%0d %s expected=%0h actual=%0h", test_name, ch, what, exp, got);
    stop_with_failure();
  endtask

  task automatic report_failure(string msg);
    $display("%s in test %s", msg, test_name);
    stop_with_failure();
  endtask

  function automatic int queued_total();
    int n;
    n = 0;
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      n += exp_smp_q[ch].size() + exp_ts_q[ch].size();
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // output capture at the falling edge, checked at the next rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge adc_clk) begin
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      smp_chk[ch].valid = adc_data_o.valid[ch];
      smp_chk[ch].have = 1'b0;
      smp_chk[ch].got = {16'h0, adc_data_o.data[ch]};
      if (adc_data_o.valid[ch] && exp_smp_q[ch].size() > 0) begin
        smp_chk[ch].have = 1'b1;
        smp_chk[ch].exp = exp_smp_q[ch].pop_front();
      end
      ts_chk[ch].valid = adc_tstamp_o.valid[ch];
      ts_chk[ch].have = 1'b0;
      ts_chk[ch].got = adc_tstamp_o.tstamp[ch];
      if (adc_tstamp_o.valid[ch] && exp_ts_q[ch].size() > 0) begin
        ts_chk[ch].have = 1'b1;
        ts_chk[ch].exp = exp_ts_q[ch].pop_front();
      end
    end
  end

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_check
    assert property (@(posedge adc_clk) smp_chk[ch].valid |-> smp_chk[ch].have)
      else report_failure($sformatf("unexpected output sample on channel %0d", ch));
    assert property (@(posedge adc_clk)
      smp_chk[ch].valid && smp_chk[ch].have |-> smp_chk[ch].got == smp_chk[ch].exp)
      else report_mismatch("sample", ch, smp_chk[ch].exp, smp_chk[ch].got);
    assert property (@(posedge adc_clk) ts_chk[ch].valid |-> ts_chk[ch].have)
      else report_failure($sformatf("unexpected timestamp on channel %0d", ch));
    assert property (@(posedge adc_clk)
      ts_chk[ch].valid && ts_chk[ch].have |-> ts_chk[ch].got == ts_chk[ch].exp)
      else report_mismatch("tstamp", ch, ts_chk[ch].exp, ts_chk[ch].got);
  end

  // nothing may leave the design under reset or reset-state
  assert property (@(posedge adc_clk) $past(reset_i || adc_reset_state_i)
    |-> adc_data_o.valid == '0 && adc_tstamp_o.valid == '0)
    else report_failure("output valid while reset-state was held");

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and reference model
  ////////////////////////////////////////////////////////////////////////////
  task automatic pick_config(int kind);
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      cfg[ch].low_thresh = sample_t'(-int'($urandom_range(200, 1500)));
      cfg[ch].high_thresh = sample_t'($urandom_range(200, 1500));
      cfg[ch].start_delay = '0;
      cfg[ch].stop_delay = '0;
      cfg[ch].dig_hold = 5'($urandom_range(0, 10));
      cfg[ch].bypass = 1'b0;
      case (kind)
        0: begin
          cfg[ch].source = 3'($urandom_range(0, 3));
          cfg[ch].bypass = (ch % 2 == 0);
        end
        1: cfg[ch].source = 3'($urandom_range(0, 3));
        2: cfg[ch].source = 3'($urandom_range(4, 5));
        default: begin
          cfg[ch].source = 3'($urandom_range(0, 5));
          cfg[ch].start_delay = 5'($urandom_range(0, 12));
          cfg[ch].stop_delay = 5'($urandom_range(0, 12));
        end
      endcase
    end
    case (kind)
      0: test_name = "bypass";
      1: test_name = "analog_hysteresis";
      2: test_name = "digital_source";
      default: test_name = "start_stop_delay";
    endcase
  endtask

  // busy inputs under reset-state, config changes only here
  task automatic apply_reset_state(int kind);
    @(negedge adc_clk);
    adc_reset_state_i = 1'b1;
    pick_config(kind);
    for (int c = 0; c < 8; c++) begin
      adc_data_i.valid = '1;
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        adc_data_i.data[ch] = sample_t'(16'h7fff);
      end
      adc_digital_trigger_i = '1;
      @(negedge adc_clk);
    end
    adc_reset_state_i = 1'b0;
    adc_data_i.valid = '0;
    adc_digital_trigger_i = '0;
  endtask

  task automatic build_stimulus();
    int center;
    center = 0;
    for (int i = 0; i < RUN_LEN; i++) begin
      // slowly wandering level so thresholds get crossed in bursts
      if (i % 16 == 0) begin
        center = int'($urandom_range(0, 8000)) - 4000;
      end
      gap[i] = int'($urandom_range(1, 4));
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        smp[ch][i] = sample_t'(center + int'($urandom_range(0, 1600)) - 800);
      end
      for (int d = 0; d < `DISC_DIG_CHANNELS; d++) begin
        pulse[i][d] = ($urandom_range(0, 29) == 0);
      end
    end
  endtask

  // samples lo..hi-1 form one segment between reset-state pulses
  task automatic build_expected(int lo, int hi);
    bit hyst [`DISC_CHANNELS];
    int hold_left [`DISC_DIG_CHANNELS];
    bit dig [`DISC_DIG_CHANNELS];
    bit take;
    bit prev_take;
    int src;
    int sd;
    int sp;
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      hyst[ch] = 1'b0;
    end
    for (int d = 0; d < `DISC_DIG_CHANNELS; d++) begin
      hold_left[d] = 0;
    end
    // trigger level per sample, seen by the gate together with that sample
    for (int i = lo; i < hi; i++) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        if ($signed(smp[ch][i]) > $signed(cfg[ch].high_thresh)) begin
          hyst[ch] = 1'b1;
        end else if ($signed(smp[ch][i]) < $signed(cfg[ch].low_thresh)) begin
          hyst[ch] = 1'b0;
        end
      end
      for (int d = 0; d < `DISC_DIG_CHANNELS; d++) begin
        if (pulse[i][d]) begin
          hold_left[d] = int'(cfg[d].dig_hold) + 1;
        end
        dig[d] = (hold_left[d] > 0);
        if (hold_left[d] > 0) begin
          hold_left[d]--;
        end
      end
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        src = int'(cfg[ch].source);
        lvl[ch][i] = (src < `DISC_CHANNELS) ? hyst[src] : dig[src-`DISC_CHANNELS];
      end
    end
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      sd = int'(cfg[ch].start_delay);
      sp = int'(cfg[ch].stop_delay);
      prev_take = 1'b0;
      for (int m = lo; m < hi; m++) begin
        if (cfg[ch].bypass) begin
          exp_smp_q[ch].push_back({16'h0, smp[ch][m]});
        end else begin
          take = 1'b0;
          for (int j = m - sp; j <= m + sd; j++) begin
            if (j >= lo && j < hi && lvl[ch][j]) begin
              take = 1'b1;
            end
          end
          // sample m only leaves when sample m+start_delay arrives
          if (m + sd >= hi) begin
            take = 1'b0;
          end
          if (take) begin
            exp_smp_q[ch].push_back({16'h0, smp[ch][m]});
            if (!prev_take) begin
              exp_ts_q[ch].push_back(32'(m - lo));
            end
          end
          prev_take = take;
        end
      end
    end
  endtask

  // reset-state is pulsed before sample split, with busy inputs while held
  task automatic send_run(int split);
    for (int i = 0; i < RUN_LEN; i++) begin
      if (i == split) begin
        @(negedge adc_clk);
        adc_data_i.valid = '0;
        adc_digital_trigger_i = '0;
        repeat (4) @(negedge adc_clk);
        adc_reset_state_i = 1'b1;
        adc_data_i.valid = '1;
        repeat (3) @(negedge adc_clk);
        adc_reset_state_i = 1'b0;
        adc_data_i.valid = '0;
      end
      @(negedge adc_clk);
      adc_data_i.valid = '1;
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        adc_data_i.data[ch] = smp[ch][i];
      end
      adc_digital_trigger_i = pulse[i];
      for (int g = 1; g < gap[i]; g++) begin
        @(negedge adc_clk);
        adc_data_i.valid = '0;
        adc_digital_trigger_i = '0;
      end
    end
    @(negedge adc_clk);
    adc_data_i.valid = '0;
    adc_digital_trigger_i = '0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (queued_total() != 0) begin
      if (cycles >= DRAIN_LIMIT) begin
        report_failure("expected outputs did not appear before the drain timeout");
      end else begin
        @(negedge adc_clk);
        cycles++;
      end
    end
  endtask

  initial begin
    int split;
    void'($urandom(91));
    reset_i = 1'b1;
    adc_reset_state_i = 1'b0;
    adc_data_i = '0;
    adc_digital_trigger_i = '0;
    cfg = '0;
    test_name = "reset";
    repeat (5) @(negedge adc_clk);
    reset_i = 1'b0;
    for (int run = 0; run < NUM_RUNS; run++) begin
      apply_reset_state(run % 4);
      // later runs also pulse reset-state halfway through
      split = (run >= 4) ? RUN_LEN / 2 : RUN_LEN;
      if (split < RUN_LEN) begin
        test_name = {test_name, "_mid_reset_state"};
      end
      build_stimulus();
      build_expected(0, split);
      if (split < RUN_LEN) begin
        build_expected(split, RUN_LEN);
      end
      send_run(split);
      wait_drain();
      repeat (8) @(negedge adc_clk);
    end
    if (queued_total() != 0) begin
      report_failure("expected outputs left over at the end");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule
